//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int WORD_SIZE = 16;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [1:0] reg_idx_t;

	// opcode field, inst[15:12]
	// JPR, JRL, WWD and HLT share OP_ALU and are told apart by funct
	typedef enum logic [3:0] {
		OP_BNE = 4'd0,
		OP_BEQ = 4'd1,
		OP_BGZ = 4'd2,
		OP_BLZ = 4'd3,
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_JMP = 4'd9,
		OP_JAL = 4'd10,
		OP_ALU = 4'd15
	} opcode_e;

	// R-type funct field, inst[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B,
		ALU_BRANCH
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_NE,
		BR_EQ,
		BR_GZ,
		BR_LZ
	} branch_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC1,
		WB_LHI
	} wb_sel_e;

	// all-zero is a harmless bubble
	typedef struct packed {
		alu_op_e  alu_op;
		logic     alu_src_imm;
		branch_e  branch;
		logic     is_jump;
		logic     is_jump_reg;
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
		reg_idx_t dest;
		wb_sel_e  wb_sel;
		logic     is_wwd;
		logic     is_halt;
	} ctrl_t;

	typedef struct packed {
		word_t inst;
		word_t pc;
		logic  valid;
	} if_id_t;

	// imm holds the jump target for JMP and JAL
	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t a;
		word_t b;
		word_t imm;
		logic  valid;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t alu_result;
		word_t b;
		logic  valid;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t alu_result;
		word_t mem_data;
		logic  valid;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire cpu_pkg::reg_idx_t read1,
	input  wire cpu_pkg::reg_idx_t read2,
	input  wire logic             write_en,
	input  wire cpu_pkg::reg_idx_t dest,
	input  wire cpu_pkg::word_t    write_data,
	output cpu_pkg::word_t         read_out1,
	output cpu_pkg::word_t         read_out2
);

	import cpu_pkg::*;

	word_t regs [4];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[dest] <= write_data;
		end
	end

	// same-cycle write goes straight to the readers
	assign read_out1 = (write_en && dest == read1) ? write_data : regs[read1];
	assign read_out2 = (write_en && dest == read2) ? write_data : regs[read2];

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  wire cpu_pkg::word_t   a,
	input  wire cpu_pkg::word_t   b,
	input  wire cpu_pkg::alu_op_e op,
	input  wire cpu_pkg::branch_e branch,
	output cpu_pkg::word_t        result,
	output logic                  bcond
);

	import cpu_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + word_t'(1);
			// shifts are always by one place
			ALU_SHL: result = {a[WORD_SIZE-2:0], 1'b0};
			ALU_SHR: result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};
			ALU_PASS_B: result = b;
			ALU_BRANCH: result = a - b;
			default: result = a + b;
		endcase
	end

	// branch condition, independent of op
	always_comb begin
		case (branch)
			BR_NE: bcond = (a != b);
			BR_EQ: bcond = (a == b);
			BR_GZ: bcond = ($signed(a) > 0);
			BR_LZ: bcond = ($signed(a) < 0);
			default: bcond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
	input  wire cpu_pkg::word_t inst,
	output cpu_pkg::ctrl_t      ctrl,
	output logic                uses_rs,
	output logic                uses_rt
);

	import cpu_pkg::*;

	opcode_e opcode;
	funct_e funct;

	assign opcode = opcode_e'(inst[15:12]);
	assign funct = funct_e'(inst[5:0]);

	always_comb begin
		ctrl = '0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			OP_ALU: begin
				ctrl.dest = inst[7:6];
				uses_rs = 1'b1;
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						ctrl.reg_write = 1'b1;
						uses_rt = 1'b1;
						if (funct == FN_ADD)
							ctrl.alu_op = ALU_ADD;
						else if (funct == FN_SUB)
							ctrl.alu_op = ALU_SUB;
						else if (funct == FN_AND)
							ctrl.alu_op = ALU_AND;
						else
							ctrl.alu_op = ALU_OR;
					end
					FN_NOT: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = ALU_NOT;
					end
					FN_TCP: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = ALU_TCP;
					end
					FN_SHL: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = ALU_SHL;
					end
					FN_SHR: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = ALU_SHR;
					end
					// rs is read through the second port, see datapath
					FN_WWD: begin
						ctrl.is_wwd = 1'b1;
						ctrl.alu_op = ALU_PASS_B;
					end
					FN_JPR: ctrl.is_jump_reg = 1'b1;
					FN_JRL: begin
						ctrl.is_jump_reg = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.dest = 2'd2;
						ctrl.wb_sel = WB_PC1;
					end
					FN_HLT: begin
						ctrl.is_halt = 1'b1;
						uses_rs = 1'b0;
					end
					default: uses_rs = 1'b0;
				endcase
			end
			OP_ADI, OP_ORI: begin
				ctrl.alu_op = (opcode == OP_ADI) ? ALU_ADD : ALU_OR;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = inst[9:8];
				uses_rs = 1'b1;
			end
			OP_LHI: begin
				ctrl.alu_op = ALU_PASS_B;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = inst[9:8];
				ctrl.wb_sel = WB_LHI;
			end
			OP_LWD: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = inst[9:8];
				ctrl.wb_sel = WB_MEM;
				uses_rs = 1'b1;
			end
			OP_SWD: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				ctrl.alu_op = ALU_BRANCH;
				uses_rs = 1'b1;
				// gz and lz only look at rs
				case (opcode)
					OP_BNE: ctrl.branch = BR_NE;
					OP_BEQ: ctrl.branch = BR_EQ;
					OP_BGZ: ctrl.branch = BR_GZ;
					default: ctrl.branch = BR_LZ;
				endcase
				uses_rt = (opcode == OP_BNE || opcode == OP_BEQ);
			end
			OP_JMP: ctrl.is_jump = 1'b1;
			OP_JAL: begin
				ctrl.is_jump = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = 2'd2;
				ctrl.wb_sel = WB_PC1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- src/hazard_detect.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detect (
	input  wire cpu_pkg::reg_idx_t rs,
	input  wire cpu_pkg::reg_idx_t rt,
	input  wire logic              uses_rs,
	input  wire logic              uses_rt,
	input  wire cpu_pkg::ctrl_t    id_ex_ctrl,
	input  wire cpu_pkg::ctrl_t    ex_mem_ctrl,
	input  wire logic              id_ex_valid,
	input  wire logic              ex_mem_valid,
	output logic                   stall
);

	import cpu_pkg::*;

	// does an in-flight writer hit one of the sources in use
	function automatic logic conflict(ctrl_t c, logic valid);
		logic writes;
		writes = valid && c.reg_write;
		return writes && ((uses_rs && rs == c.dest) || (uses_rt && rt == c.dest));
	endfunction

	// MEM/WB is covered by the register file bypass
	assign stall = conflict(id_ex_ctrl, id_ex_valid) || conflict(ex_mem_ctrl, ex_mem_valid);

endmodule

`default_nettype wire

//--- src/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  wire logic           clk,
	input  wire logic           rst,
	output logic                read_m1,
	output cpu_pkg::word_t      address1,
	input  wire cpu_pkg::word_t data1,
	output logic                read_m2,
	output logic                write_m2,
	output cpu_pkg::word_t      address2,
	output cpu_pkg::word_t      write_data2,
	input  wire cpu_pkg::word_t data2,
	output cpu_pkg::word_t      num_inst,
	output cpu_pkg::word_t      output_port,
	output logic                is_halted
);

	import cpu_pkg::*;

	word_t pc;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	// decode stage
	ctrl_t id_ctrl;
	logic uses_rs;
	logic uses_rt;
	reg_idx_t id_rs;
	reg_idx_t id_rt;
	reg_idx_t rf_read2;
	word_t read_out1;
	word_t read_out2;
	word_t id_imm;
	logic stall;
	logic id_go;

	// execute stage
	word_t alu_b;
	word_t alu_result;
	logic bcond;
	logic redirect;
	word_t ex_target;

	// write back
	logic wb_en;
	word_t wb_data;

	logic fetch_stop;
	logic fetch_en;

	// no fetch once HLT sits in ID or has moved past it
	assign fetch_en = !fetch_stop && !(if_id.valid && id_ctrl.is_halt);
	assign read_m1 = fetch_en;
	assign address1 = pc;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (redirect)
			pc <= ex_target;
		else if (!stall && fetch_en)
			pc <= pc + word_t'(1);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			if_id.valid <= 1'b0;
		end else if (redirect) begin
			if_id.valid <= 1'b0;
		end else if (!stall) begin
			if_id.valid <= fetch_en;
			if_id.inst <= data1;
			if_id.pc <= pc;
		end
	end

	assign id_rs = if_id.inst[11:10];
	assign id_rt = if_id.inst[9:8];
	// WWD shows rs, so route it to the B read port
	assign rf_read2 = id_ctrl.is_wwd ? id_rs : id_rt;

	control_unit control_unit_i (
		.inst(if_id.inst),
		.ctrl(id_ctrl),
		.uses_rs(uses_rs),
		.uses_rt(uses_rt)
	);

	hazard_detect hazard_detect_i (
		.rs(id_rs),
		.rt(id_rt),
		.uses_rs(if_id.valid && uses_rs),
		.uses_rt(if_id.valid && uses_rt),
		.id_ex_ctrl(id_ex.ctrl),
		.ex_mem_ctrl(ex_mem.ctrl),
		.id_ex_valid(id_ex.valid),
		.ex_mem_valid(ex_mem.valid),
		.stall(stall)
	);

	register_file register_file_i (
		.clk(clk),
		.rst(rst),
		.read1(id_rs),
		.read2(rf_read2),
		.write_en(wb_en),
		.dest(mem_wb.ctrl.dest),
		.write_data(wb_data),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	// jump target rides in the immediate slot
	assign id_imm = id_ctrl.is_jump ? {if_id.pc[15:12], if_id.inst[11:0]}
		: {{(WORD_SIZE-8){if_id.inst[7]}}, if_id.inst[7:0]};

	assign id_go = if_id.valid && !stall && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl <= '0;
			fetch_stop <= 1'b0;
		end else begin
			id_ex.valid <= id_go;
			id_ex.ctrl <= id_go ? id_ctrl : ctrl_t'('0);
			id_ex.pc <= if_id.pc;
			id_ex.a <= read_out1;
			id_ex.b <= read_out2;
			id_ex.imm <= id_imm;
			if (id_go && id_ctrl.is_halt)
				fetch_stop <= 1'b1;
		end
	end

	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.b;

	alu alu_i (
		.a(id_ex.a),
		.b(alu_b),
		.op(id_ex.ctrl.alu_op),
		.branch(id_ex.ctrl.branch),
		.result(alu_result),
		.bcond(bcond)
	);

	always_comb begin
		if (id_ex.ctrl.is_jump_reg)
			ex_target = id_ex.a;
		else if (id_ex.ctrl.is_jump)
			ex_target = id_ex.imm;
		else
			ex_target = id_ex.pc + word_t'(1) + id_ex.imm;
	end

	// fall-through is predicted, so any taken transfer flushes IF/ID and ID/EX
	assign redirect = id_ex.valid && (id_ex.ctrl.is_jump || id_ex.ctrl.is_jump_reg
		|| (id_ex.ctrl.branch != BR_NONE && bcond));

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl <= '0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.pc <= id_ex.pc;
			ex_mem.alu_result <= alu_result;
			ex_mem.b <= id_ex.b;
		end
	end

	assign read_m2 = ex_mem.valid && ex_mem.ctrl.mem_read;
	assign write_m2 = ex_mem.valid && ex_mem.ctrl.mem_write;
	assign address2 = ex_mem.alu_result;
	assign write_data2 = ex_mem.b;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.valid <= 1'b0;
			mem_wb.ctrl <= '0;
		end else begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.ctrl <= ex_mem.ctrl;
			mem_wb.pc <= ex_mem.pc;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.mem_data <= data2;
		end
	end

	assign wb_en = mem_wb.valid && mem_wb.ctrl.reg_write;

	always_comb begin
		case (mem_wb.ctrl.wb_sel)
			WB_MEM: wb_data = mem_wb.mem_data;
			WB_PC1: wb_data = mem_wb.pc + word_t'(1);
			// LHI immediate goes to the upper byte
			WB_LHI: wb_data = {mem_wb.alu_result[7:0], 8'h00};
			default: wb_data = mem_wb.alu_result;
		endcase
	end

	// retire counters and ports
	always_ff @(posedge clk) begin
		if (rst) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (mem_wb.valid) begin
			num_inst <= num_inst + word_t'(1);
			if (mem_wb.ctrl.is_wwd)
				output_port <= mem_wb.alu_result;
			if (mem_wb.ctrl.is_halt)
				is_halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic word_t enc_r(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
	return {OP_ALU, rs, rt, rd, fn};
endfunction

function automatic word_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(opcode_e op, logic [11:0] target);
	return {op, target};
endfunction

function automatic void load_program();
	// unused words hold HLT with the address in the register fields
	for (int i = 0; i < 64; i++) begin
		imem[i] = {4'hf, 6'(i), 6'd29};
	end
	// loads, then dependent ALU ops at distances one to three
	imem[0] = enc_i(OP_LWD, 2'd3, 2'd0, 8'd0);
	imem[1] = enc_i(OP_LWD, 2'd3, 2'd1, 8'd1);
	imem[2] = enc_r(FN_ADD, 2'd0, 2'd1, 2'd2);
	imem[3] = enc_r(FN_WWD, 2'd2, 2'd0, 2'd0);
	imem[4] = enc_r(FN_SUB, 2'd2, 2'd0, 2'd3);
	imem[5] = enc_r(FN_AND, 2'd0, 2'd1, 2'd2);
	imem[6] = enc_r(FN_ORR, 2'd0, 2'd1, 2'd0);
	imem[7] = enc_r(FN_WWD, 2'd3, 2'd0, 2'd0);
	imem[8] = enc_r(FN_WWD, 2'd2, 2'd0, 2'd0);
	imem[9] = enc_r(FN_NOT, 2'd0, 2'd0, 2'd1);
	imem[10] = enc_r(FN_WWD, 2'd1, 2'd0, 2'd0);
	imem[11] = enc_r(FN_TCP, 2'd1, 2'd0, 2'd2);
	imem[12] = enc_r(FN_SHL, 2'd2, 2'd0, 2'd3);
	imem[13] = enc_r(FN_WWD, 2'd3, 2'd0, 2'd0);
	imem[14] = enc_r(FN_SHR, 2'd3, 2'd0, 2'd3);
	imem[15] = enc_r(FN_WWD, 2'd3, 2'd0, 2'd0);
	imem[16] = enc_i(OP_LHI, 2'd0, 2'd0, 8'h9c);
	imem[17] = enc_i(OP_ORI, 2'd0, 2'd0, 8'h35);
	imem[18] = enc_i(OP_ADI, 2'd0, 2'd1, 8'hfe);
	imem[19] = enc_r(FN_WWD, 2'd1, 2'd0, 2'd0);
	// r3 = 8 as a base for stores
	imem[20] = enc_i(OP_LHI, 2'd0, 2'd3, 8'h00);
	imem[21] = enc_i(OP_ADI, 2'd3, 2'd3, 8'd8);
	imem[22] = enc_i(OP_SWD, 2'd3, 2'd1, 8'd2);
	imem[23] = enc_i(OP_LWD, 2'd3, 2'd2, 8'd2);
	imem[24] = enc_r(FN_ADD, 2'd2, 2'd0, 2'd2);
	imem[25] = enc_i(OP_SWD, 2'd3, 2'd2, 8'hff);
	imem[26] = enc_i(OP_LWD, 2'd3, 2'd0, 8'd3);
	imem[27] = enc_r(FN_WWD, 2'd0, 2'd0, 2'd0);
	// branches, the skipped slots must stay silent
	imem[28] = enc_i(OP_BEQ, 2'd3, 2'd3, 8'd1);
	imem[29] = enc_r(FN_WWD, 2'd3, 2'd0, 2'd0);
	imem[30] = enc_i(OP_BNE, 2'd3, 2'd3, 8'd5);
	imem[31] = enc_i(OP_BGZ, 2'd3, 2'd0, 8'd1);
	imem[32] = enc_i(OP_SWD, 2'd3, 2'd0, 8'd0);
	imem[33] = enc_i(OP_BLZ, 2'd3, 2'd0, 8'd2);
	imem[34] = enc_r(FN_TCP, 2'd3, 2'd0, 2'd1);
	imem[35] = enc_i(OP_BLZ, 2'd1, 2'd0, 8'd1);
	imem[36] = enc_r(FN_WWD, 2'd3, 2'd0, 2'd0);
	imem[37] = enc_i(OP_BGZ, 2'd1, 2'd0, 8'd3);
	imem[38] = enc_i(OP_BNE, 2'd1, 2'd3, 8'd1);
	imem[39] = enc_r(FN_HLT, 2'd0, 2'd0, 2'd0);
	// jumps and links
	imem[40] = enc_j(OP_JAL, 12'd44);
	imem[41] = enc_i(OP_ADI, 2'd2, 2'd2, 8'd1);
	imem[42] = enc_j(OP_JMP, 12'd48);
	imem[43] = enc_r(FN_WWD, 2'd0, 2'd0, 2'd0);
	imem[44] = enc_r(FN_WWD, 2'd2, 2'd0, 2'd0);
	imem[45] = enc_r(FN_JPR, 2'd2, 2'd0, 2'd0);
	imem[46] = enc_i(OP_SWD, 2'd3, 2'd0, 8'd0);
	imem[47] = enc_r(FN_WWD, 2'd1, 2'd0, 2'd0);
	imem[48] = enc_r(FN_WWD, 2'd2, 2'd0, 2'd0);
	imem[49] = enc_i(OP_LHI, 2'd0, 2'd1, 8'h00);
	imem[50] = enc_i(OP_ADI, 2'd1, 2'd1, 8'd54);
	imem[51] = enc_r(FN_JRL, 2'd1, 2'd0, 2'd0);
	imem[52] = enc_r(FN_WWD, 2'd0, 2'd0, 2'd0);
	imem[53] = enc_i(OP_SWD, 2'd3, 2'd1, 8'd0);
	imem[54] = enc_r(FN_WWD, 2'd2, 2'd0, 2'd0);
	imem[55] = enc_r(FN_HLT, 2'd0, 2'd0, 2'd0);
	imem[56] = enc_r(FN_WWD, 2'd1, 2'd0, 2'd0);
endfunction

// one instruction at a time, no pipeline
function automatic void run_reference_model();
	word_t r [4];
	word_t mem [256];
	word_t pc;
	word_t next;
	word_t inst;
	word_t a;
	word_t b;
	word_t imm;
	word_t addr;
	word_t shown;
	store_t st;
	reg_idx_t rt;
	reg_idx_t rd;
	logic done;
	int steps;
	for (int i = 0; i < 256; i++) begin
		mem[i] = dmem[i];
	end
	for (int i = 0; i < 4; i++) begin
		r[i] = '0;
	end
	pc = '0;
	shown = '0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1000) begin
		inst = imem[pc[5:0]];
		a = r[inst[11:10]];
		b = r[inst[9:8]];
		rt = inst[9:8];
		rd = inst[7:6];
		imm = {{8{inst[7]}}, inst[7:0]};
		addr = a + imm;
		next = pc + 16'd1;
		case (opcode_e'(inst[15:12]))
			OP_ADI: r[rt] = a + imm;
			OP_ORI: r[rt] = a | imm;
			OP_LHI: r[rt] = {inst[7:0], 8'h00};
			OP_LWD: r[rt] = mem[addr[7:0]];
			OP_SWD: begin
				mem[addr[7:0]] = b;
				st.addr = addr;
				st.data = b;
				exp_stores.push_back(st);
			end
			OP_BNE: if (a != b) next = pc + 16'd1 + imm;
			OP_BEQ: if (a == b) next = pc + 16'd1 + imm;
			OP_BGZ: if (!a[15] && a != 16'd0) next = pc + 16'd1 + imm;
			OP_BLZ: if (a[15]) next = pc + 16'd1 + imm;
			OP_JMP: next = {pc[15:12], inst[11:0]};
			OP_JAL: begin
				r[2] = pc + 16'd1;
				next = {pc[15:12], inst[11:0]};
			end
			OP_ALU: begin
				case (funct_e'(inst[5:0]))
					FN_ADD: r[rd] = a + b;
					FN_SUB: r[rd] = a - b;
					FN_AND: r[rd] = a & b;
					FN_ORR: r[rd] = a | b;
					FN_NOT: r[rd] = ~a;
					FN_TCP: r[rd] = 16'd0 - a;
					FN_SHL: r[rd] = {a[14:0], 1'b0};
					FN_SHR: r[rd] = {a[15], a[15:1]};
					// output_port only shows a change
					FN_WWD: begin
						if (a != shown)
							exp_wwd.push_back(a);
						shown = a;
					end
					FN_JPR: next = a;
					FN_JRL: begin
						r[2] = pc + 16'd1;
						next = a;
					end
					FN_HLT: done = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
		steps++;
		pc = next;
	end
	exp_count = 16'(steps);
endfunction

`endif

//--- verification/tb_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module tb_datapath;

	import cpu_pkg::*;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic clk;
	logic rst;
	logic read_m1;
	word_t address1;
	word_t data1;
	logic read_m2;
	logic write_m2;
	word_t address2;
	word_t write_data2;
	word_t data2;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t imem [64];
	word_t dmem [256];

	// expected results from the reference model
	word_t exp_wwd [$];
	store_t exp_stores [$];
	word_t exp_count;

	logic [31:0] lfsr_state;
	word_t last_out;
	int cycles;

	`include "tb_isa_model.svh"

	datapath #(
		.RESET_PC(16'h0000)
	) datapath_i (
		.clk(clk),
		.rst(rst),
		.read_m1(read_m1),
		.address1(address1),
		.data1(data1),
		.read_m2(read_m2),
		.write_m2(write_m2),
		.address2(address2),
		.write_data2(write_data2),
		.data2(data2),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// both memories answer in the same cycle and only when read
	assign data1 = read_m1 ? imem[address1[5:0]] : '0;
	assign data2 = read_m2 ? dmem[address2[7:0]] : '0;

	always @(posedge clk) begin
		if (!rst && write_m2)
			dmem[address2[7:0]] <= write_data2;
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic word_t next_random_word();
		word_t w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return w;
	endfunction

	function automatic void fill_data_memory();
		for (int i = 0; i < 256; i++) begin
			if (i < 16)
				dmem[i] = next_random_word();
			else
				dmem[i] = {~8'(i), 8'(i)};
		end
	endfunction

	task automatic report_failure(string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
			report_failure("value check failed");
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
			report_failure("flag check failed");
		end
	endtask

	task automatic check_store(store_t got, store_t exp);
		if (got !== exp) begin
			$display("mismatch address2/write_data2 got 0x%h/0x%h expected 0x%h/0x%h",
				got.addr, got.data, exp.addr, exp.data);
			report_failure("store check failed");
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		store_t seen;
		if (!rst) begin
			if (output_port !== last_out) begin
				if (exp_wwd.size() == 0)
					report_failure("output_port changed when no WWD value was expected");
				else
					check_word("output_port", output_port, exp_wwd.pop_front());
				last_out = output_port;
			end
			if (write_m2) begin
				seen.addr = address2;
				seen.data = write_data2;
				if (exp_stores.size() == 0)
					report_failure("a store occurred when none was expected");
				else
					check_store(seen, exp_stores.pop_front());
			end
			// no fetch once halted
			if (is_halted)
				check_bit("read_m1", read_m1, 1'b0);
		end
	end

	initial begin
		rst = 1'b1;
		lfsr_state = 32'haacf_9c4c;
		last_out = '0;
		load_program();
		fill_data_memory();
		run_reference_model();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		cycles = 0;
		while (!is_halted && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (!is_halted)
			report_failure("timed out waiting for is_halted");
		check_word("num_inst", num_inst, exp_count);
		// nothing may retire or show up after halt
		repeat (20) @(negedge clk);
		check_word("num_inst", num_inst, exp_count);
		check_bit("is_halted", is_halted, 1'b1);
		if (exp_wwd.size() != 0 || exp_stores.size() != 0) begin
			report_failure("expected WWD values or stores never appeared");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verification
src/cpu_pkg.sv
src/register_file.sv
src/alu.sv
src/control_unit.sv
src/hazard_detect.sv
src/datapath.sv
verification/tb_datapath.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_datapath -f verilog.f -o Vtb_datapath
./obj_dir/Vtb_datapath | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
